//--- design/sqrt_macros.svh
`ifndef SQRT_MACROS_SVH
`define SQRT_MACROS_SVH

// single precision float fields
`define SQRT_EXP_W 8
`define SQRT_MAN_W 23
`define SQRT_EXP_BIAS 127

// working fixed point width
// aligned mantissa is Q2.26, reciprocal and temporaries are Q1.27
`define SQRT_FIX_W 28

// reciprocal root seed table
`define SQRT_SEED_BITS 5
`define SQRT_NEWTON_ITERS 3

// bus register map
`define SQRT_ADR_DATA 0
`define SQRT_ADR_STATUS 1

`endif

//--- design/sqrt_pkg.sv
`include "sqrt_macros.svh"

package sqrt_pkg;

   typedef logic [31:0] word_t;
   typedef logic [`SQRT_EXP_W-1:0] exp_t;
   typedef logic [`SQRT_MAN_W-1:0] man_t;
   typedef logic [`SQRT_FIX_W-1:0] fix_t;
   typedef logic [`SQRT_SEED_BITS-1:0] seed_idx_t;

   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      logic  adr;
      word_t dat_w;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat_r;
   } wb_rsp_t;

   typedef enum logic [2:0] {
      cls_normal,
      cls_zero,
      cls_inf,
      cls_nan,
      cls_negative
   } op_class_t;

   typedef struct packed {
      logic      sign;
      op_class_t cls;
      exp_t      exp;   // biased exponent of the root
      fix_t      am;    // aligned mantissa in [1,4), nan payload for nan
   } unpacked_t;

   typedef enum logic [3:0] {
      st_idle,
      st_unpack,
      st_seed,
      st_square,
      st_scale,
      st_refine,
      st_root,
      st_check,
      st_pack
   } ctrl_state_t;

   typedef enum logic [2:0] {
      dp_idle,
      dp_load,
      dp_square,
      dp_scale,
      dp_refine,
      dp_root,
      dp_check
   } dp_op_t;

endpackage

//--- design/operand_unpack.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module operand_unpack import sqrt_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      unpack_en,
   input  word_t     operand,
   output unpacked_t unp
);

   function automatic logic [4:0] lead_zeros(input man_t m);
      logic [4:0] n;
      logic       found;
      n = 5'd0;
      found = 1'b0;
      for (int i = `SQRT_MAN_W - 1; i >= 0; i--) begin
         if (!found && !m[i])
            n = n + 5'd1;
         else
            found = 1'b1;
      end
      return n;
   endfunction

   logic  s;
   exp_t  e;
   man_t  m;
   logic [4:0] lz;
   logic [4:0] k;
   logic signed [9:0] unb;
   logic signed [9:0] half;
   unpacked_t unp_d;

   always_comb begin
      s  = operand[31];
      e  = operand[30:23];
      m  = operand[22:0];
      lz = lead_zeros(m);
      k  = (lz + 5'd2) >> 1;   // even shift of 2k puts the top one in bit 27 or 26
      if (e == '0) begin
         unb = 10'sd1 - 10'(`SQRT_EXP_BIAS) - 10'({k, 1'b0});
         unp_d.am = fix_t'({m, 3'b000}) << {k, 1'b0};
      end else begin
         unb = $signed({2'b00, e}) - 10'(`SQRT_EXP_BIAS);
         unp_d.am = unb[0] ? {1'b1, m, 4'b0000} : {2'b01, m, 3'b000};  // odd exponent doubles
      end
      half = unb >>> 1;
      unp_d.exp  = exp_t'(half + 10'(`SQRT_EXP_BIAS));
      unp_d.sign = s;

      if (e == '1)
         unp_d.cls = (m != '0) ? cls_nan : (s ? cls_negative : cls_inf);
      else if (e == '0 && m == '0)
         unp_d.cls = cls_zero;
      else if (s)
         unp_d.cls = cls_negative;
      else
         unp_d.cls = cls_normal;

      // specials still run the datapath, keep it on a harmless value
      if (unp_d.cls == cls_nan)
         unp_d.am = fix_t'(m);   // payload rides along to the packer
      else if (unp_d.cls == cls_zero || unp_d.cls == cls_inf)
         unp_d.am = fix_t'(1) << (`SQRT_FIX_W - 2);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         unp <= '0;
      else if (unpack_en)
         unp <= unp_d;
   end

endmodule

//--- design/rsqrt_seed.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module rsqrt_seed import sqrt_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      seed_en,
   input  unpacked_t unp,
   output fix_t      seed
);

   // 1/sqrt of interval midpoint (i+0.5)/8, scaled by 256
   function automatic logic [7:0] seed_entry(input seed_idx_t i);
      case (i)
         5'd8:    return 8'd248;
         5'd9:    return 8'd235;
         5'd10:   return 8'd223;
         5'd11:   return 8'd214;
         5'd12:   return 8'd205;
         5'd13:   return 8'd197;
         5'd14:   return 8'd190;
         5'd15:   return 8'd184;
         5'd16:   return 8'd178;
         5'd17:   return 8'd173;
         5'd18:   return 8'd168;
         5'd19:   return 8'd164;
         5'd20:   return 8'd160;
         5'd21:   return 8'd156;
         5'd22:   return 8'd153;
         5'd23:   return 8'd149;
         5'd24:   return 8'd146;
         5'd25:   return 8'd143;
         5'd26:   return 8'd141;
         5'd27:   return 8'd138;
         5'd28:   return 8'd136;
         5'd29:   return 8'd133;
         5'd30:   return 8'd131;
         5'd31:   return 8'd129;
         default: return 8'd255;   // below 1.0, only reached by specials
      endcase
   endfunction

   seed_idx_t idx;

   assign idx = unp.am[`SQRT_FIX_W-1 -: `SQRT_SEED_BITS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         seed <= '0;
      else if (seed_en)
         seed <= {1'b0, seed_entry(idx), {(`SQRT_FIX_W - 9){1'b0}}};  // to Q1.27
   end

endmodule

//--- design/newton_datapath.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module newton_datapath import sqrt_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  dp_op_t    dp_op,
   input  unpacked_t unp,
   input  fix_t      seed,
   output fix_t      root,
   output logic      root_low
);

   localparam int PW  = 2 * `SQRT_FIX_W;
   localparam int RF  = `SQRT_FIX_W - 1;        // frac bits of r and t
   localparam int AF  = `SQRT_FIX_W - 2;        // frac bits of am and root
   localparam int ULP = AF + RF - (`SQRT_MAN_W + 1);

   // round to nearest while dropping sh bits
   function automatic fix_t rnd(input logic [PW-1:0] p, input int sh);
      logic [PW-1:0] one;
      logic [PW-1:0] s;
      one = 1;
      s = (p + (one << (sh - 1))) >> sh;
      return s[`SQRT_FIX_W-1:0];
   endfunction

   fix_t r;
   fix_t t;
   fix_t root_q;
   logic root_low_q;
   logic seeded;
   fix_t mul_a;
   fix_t mul_b;
   fix_t half_corr;
   logic [`SQRT_FIX_W:0] three_minus;
   logic [PW-1:0] prod;
   logic [PW-1:0] q_biased;

   always_comb begin
      three_minus = ((`SQRT_FIX_W + 1)'(3) << RF) - {1'b0, t} + 1'b1;
      half_corr   = three_minus[`SQRT_FIX_W:1];   // (3 - t)/2
      case (dp_op)
         dp_load:   begin mul_a = seed;   mul_b = seed;      end
         dp_scale:  begin mul_a = t;      mul_b = unp.am;    end
         dp_refine: begin mul_a = r;      mul_b = half_corr; end
         dp_root:   begin mul_a = unp.am; mul_b = r;         end
         dp_check:  begin mul_a = root_q + fix_t'(4); mul_b = root_q + fix_t'(4); end
         default:   begin mul_a = r;      mul_b = r;         end
      endcase
      prod = PW'(mul_a) * PW'(mul_b);   // the one shared multiplier
      q_biased = prod - (PW'(1) << (ULP - 1));   // half ulp low so truncation never overshoots
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r          <= '0;
         t          <= '0;
         root_q     <= '0;
         root_low_q <= 1'b0;
         seeded     <= 1'b0;
      end else begin
         case (dp_op)
            dp_load: begin
               r      <= seed;
               t      <= rnd(prod, RF);
               seeded <= 1'b1;
            end
            dp_square: t <= rnd(prod, RF);
            dp_scale:  t <= rnd(prod, AF);
            dp_refine: r <= rnd(prod, RF);
            dp_root:   root_q <= {1'b0, q_biased[AF+RF:ULP], 2'b00};
            dp_check: begin
               root_low_q <= (prod <= {unp.am, {AF{1'b0}}});  // next ulp still fits
               seeded     <= 1'b0;
            end
            default: ;
         endcase
      end
   end

   assign root     = root_q;
   assign root_low = root_low_q;

   a_seed_first: assert property (@(posedge clk) disable iff (!arst_n)
      (dp_op inside {dp_square, dp_scale, dp_refine, dp_root, dp_check}) |-> seeded);

endmodule

//--- design/result_pack.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module result_pack import sqrt_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      pack_en,
   input  unpacked_t unp,
   input  fix_t      root,
   input  logic      root_low,
   output word_t     result,
   output logic      result_exc
);

   logic [`SQRT_MAN_W+1:0] exact;     // 25 bit truncated root
   logic [`SQRT_MAN_W+1:0] rounded;
   exp_t  exp_out;
   word_t word_d;
   logic  exc_d;

   always_comb begin
      exact   = root[`SQRT_FIX_W-2:2] + {{(`SQRT_MAN_W + 1){1'b0}}, root_low};
      rounded = {1'b0, exact[`SQRT_MAN_W+1:1]} + {{(`SQRT_MAN_W + 1){1'b0}}, exact[0]};
      exp_out = unp.exp + exp_t'(rounded[`SQRT_MAN_W+1]);  // carry out of the mantissa

      exc_d = 1'b0;
      case (unp.cls)
         cls_nan: begin
            word_d = {unp.sign, 8'hff, 1'b1, unp.am[`SQRT_MAN_W-2:0]};  // quieted
            exc_d  = 1'b1;
         end
         cls_inf:  word_d = {1'b0, 8'hff, 23'd0};
         cls_zero: word_d = {unp.sign, 31'd0};
         cls_negative: begin
            word_d = {1'b1, 8'hff, 1'b1, 22'd0};
            exc_d  = 1'b1;
         end
         default: word_d = {1'b0, exp_out, rounded[`SQRT_MAN_W-1:0]};
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result     <= '0;
         result_exc <= 1'b0;
      end else if (pack_en) begin
         result     <= word_d;
         result_exc <= exc_d;
      end
   end

endmodule

//--- design/sqrt_ctrl.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module sqrt_ctrl import sqrt_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp,
   output word_t   operand,
   output logic    unpack_en,
   output logic    seed_en,
   output logic    pack_en,
   output dp_op_t  dp_op,
   input  word_t   result,
   input  logic    result_exc
);

   localparam int unsigned IW = $clog2(`SQRT_NEWTON_ITERS + 1);

   ctrl_state_t state;
   ctrl_state_t state_nx;
   logic [IW-1:0] iter;
   logic  ack_q;
   logic  done_q;
   logic  exc_q;
   logic  busy;
   logic  req;
   logic  is_status;
   logic  accept;
   logic  start;
   word_t operand_q;
   word_t result_q;
   word_t dat_r_q;

   assign req       = wb_req.cyc & wb_req.stb & ~ack_q;   // one ack per cycle
   assign is_status = (wb_req.adr == 1'(`SQRT_ADR_STATUS));
   assign busy      = (state != st_idle) | done_q;
   assign accept    = req & (is_status | ~busy);          // data access waits for idle
   assign start     = accept & wb_req.we & (wb_req.adr == 1'(`SQRT_ADR_DATA));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_q  <= 1'b0;
         done_q <= 1'b0;
         exc_q  <= 1'b0;
      end else begin
         ack_q  <= accept;
         done_q <= pack_en;
         if (done_q)
            exc_q <= result_exc;
      end
   end

   always_ff @(posedge clk) begin
      if (start)
         operand_q <= wb_req.dat_w;
      if (done_q)
         result_q <= result;
      if (accept)
         dat_r_q <= is_status ? {30'd0, exc_q, busy} : result_q;
   end

   // sequencer
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
         iter  <= '0;
      end else begin
         state <= state_nx;
         if (state == st_seed)
            iter <= '0;
         else if (state == st_refine)
            iter <= iter + 1'b1;
      end
   end

   always_comb begin
      state_nx = state;
      case (state)
         st_idle:   if (start) state_nx = st_unpack;
         st_unpack: state_nx = st_seed;
         st_seed:   state_nx = st_square;
         st_square: state_nx = st_scale;
         st_scale:  state_nx = st_refine;
         st_refine: state_nx = (iter == IW'(`SQRT_NEWTON_ITERS - 1)) ? st_root : st_square;
         st_root:   state_nx = st_check;
         st_check:  state_nx = st_pack;
         default:   state_nx = st_idle;
      endcase
   end

   always_comb begin
      case (state)
         st_square: dp_op = (iter == '0) ? dp_load : dp_square;  // first pass squares the seed
         st_scale:  dp_op = dp_scale;
         st_refine: dp_op = dp_refine;
         st_root:   dp_op = dp_root;
         st_check:  dp_op = dp_check;
         default:   dp_op = dp_idle;
      endcase
   end

   assign unpack_en = (state == st_unpack);
   assign seed_en   = (state == st_seed);
   assign pack_en   = (state == st_pack);
   assign operand   = operand_q;

   assign wb_rsp.ack   = ack_q;
   assign wb_rsp.dat_r = dat_r_q;

   a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

   // newton loop stays within its count
   a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(state) && (state inside {st_idle, st_unpack, st_seed, st_square,
         st_scale, st_refine, st_root, st_check, st_pack}) &&
      (!(state inside {st_square, st_scale, st_refine}) ||
         (iter < IW'(`SQRT_NEWTON_ITERS))));

   // operand may not move under a running operation
   a_operand_held: assert property (@(posedge clk) disable iff (!arst_n)
      (state != st_idle) |=> $stable(operand_q));

endmodule

//--- design/sqrt_top.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module sqrt_top import sqrt_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  wb_req_t wb_req,
   output wb_rsp_t wb_rsp
);

   word_t     operand;
   word_t     result;
   logic      result_exc;
   logic      unpack_en;
   logic      seed_en;
   logic      pack_en;
   dp_op_t    dp_op;
   unpacked_t unp;
   fix_t      seed;
   fix_t      root;
   logic      root_low;

   sqrt_ctrl i_sqrt_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .operand    (operand),
      .unpack_en  (unpack_en),
      .seed_en    (seed_en),
      .pack_en    (pack_en),
      .dp_op      (dp_op),
      .result     (result),
      .result_exc (result_exc)
   );

   operand_unpack i_operand_unpack (
      .clk       (clk),
      .arst_n    (arst_n),
      .unpack_en (unpack_en),
      .operand   (operand),
      .unp       (unp)
   );

   rsqrt_seed i_rsqrt_seed (
      .clk     (clk),
      .arst_n  (arst_n),
      .seed_en (seed_en),
      .unp     (unp),
      .seed    (seed)
   );

   newton_datapath i_newton_datapath (
      .clk      (clk),
      .arst_n   (arst_n),
      .dp_op    (dp_op),
      .unp      (unp),
      .seed     (seed),
      .root     (root),
      .root_low (root_low)
   );

   result_pack i_result_pack (
      .clk        (clk),
      .arst_n     (arst_n),
      .pack_en    (pack_en),
      .unp        (unp),
      .root       (root),
      .root_low   (root_low),
      .result     (result),
      .result_exc (result_exc)
   );

endmodule

//--- bench/sqrt_tb.sv
`timescale 1ns/100ps
`include "sqrt_macros.svh"

module sqrt_tb import sqrt_pkg::*; ();

   localparam int N_NORMAL   = 1200;
   localparam int N_DENORM   = 300;
   localparam int MAX_CYCLES = 2000 * 40;

   logic        clk;
   logic        arst_n;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [31:0] lfsr;
   int          cycles = 0;

   sqrt_top i_sqrt_top (
      .clk    (clk),
      .arst_n (arst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
         $display("Done: errors found");
         $fatal(1, "run stopped by cycle limit");
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // one lfsr step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic logic [31:0] isqrt(input logic [63:0] a);
      logic [31:0] r;
      logic [31:0] t;
      r = '0;
      for (int b = 31; b >= 0; b--) begin
         t = r | (32'd1 << b);
         if ({32'd0, t} * {32'd0, t} <= a)
            r = t;
      end
      return r;
   endfunction

   // returns {exception, result word}
   function automatic logic [32:0] model_sqrt(input logic [31:0] x);
      logic        s;
      logic [7:0]  e;
      logic [22:0] m;
      logic [23:0] sig;
      logic [63:0] a;
      logic [31:0] r;
      logic [24:0] rm;
      int          p;
      int          unb;
      int          half;
      int          ex;
      s = x[31];
      e = x[30:23];
      m = x[22:0];
      if (e == 8'hff && m != '0)
         return {1'b1, s, 8'hff, 1'b1, m[21:0]};   // quiet nan, payload kept
      if (e == 8'h00 && m == '0)
         return {1'b0, s, 31'd0};
      if (s)
         return {1'b1, 32'hffc0_0000};
      if (e == 8'hff)
         return {1'b0, 32'h7f80_0000};
      if (e == 8'h00) begin
         p = 0;
         for (int i = 0; i < 23; i++) begin
            if (m[i])
               p = i;
         end
         sig = {1'b0, m} << (23 - p);   // normalize denormal
         unb = 1 - `SQRT_EXP_BIAS - (23 - p);
      end else begin
         sig = {1'b1, m};
         unb = int'(e) - `SQRT_EXP_BIAS;
      end
      // odd exponent moves a factor of two into the mantissa
      if ((unb & 1) != 0)
         a = {40'd0, sig} << 26;
      else
         a = {40'd0, sig} << 25;
      half = (unb - (unb & 1)) / 2;
      r    = isqrt(a);                  // 25 significant bits
      rm   = r[25:1] + {24'd0, r[0]};
      ex   = half + `SQRT_EXP_BIAS + int'(rm[24]);
      return {1'b0, 1'b0, 8'(ex), rm[22:0]};
   endfunction

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      if (got !== expected) begin
         $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdat,
                            output logic [31:0] rdat, output int waited);
      @(negedge clk);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = we;
      wb_req.adr   = adr;
      wb_req.dat_w = wdat;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_rsp.ack);
      rdat = wb_rsp.dat_r;
      @(negedge clk);      // stb stays up over the ack edge
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic write_data(input logic [31:0] x, output int waited);
      logic [31:0] unused_rdat;
      bus_cycle(1'b1, 1'(`SQRT_ADR_DATA), x, unused_rdat, waited);
   endtask

   task automatic read_data(output logic [31:0] d, output int waited);
      bus_cycle(1'b0, 1'(`SQRT_ADR_DATA), 32'd0, d, waited);
   endtask

   task automatic read_status(output logic [31:0] d);
      int waited;
      bus_cycle(1'b0, 1'(`SQRT_ADR_STATUS), 32'd0, d, waited);
      check("status ack wait", 32'(waited), 32'd1);
   endtask

   // write, held-off read, then status
   task automatic run_operand(input logic [31:0] x);
      logic [32:0] expv;
      logic [31:0] d;
      int          waited;
      expv = model_sqrt(x);
      write_data(x, waited);
      check($sformatf("write ack wait for %h", x), 32'(waited), 32'd1);
      read_data(d, waited);
      check($sformatf("read held off for %h", x), 32'(waited > 1), 32'd1);
      check($sformatf("result for %h", x), d, expv[31:0]);
      read_status(d);
      check($sformatf("status for %h", x), d, {30'd0, expv[32], 1'b0});
   endtask

   initial begin : main
      logic [31:0] v;
      logic [31:0] w;
      logic [31:0] x;
      logic [31:0] d;
      logic [7:0]  e;
      logic [32:0] exp_a;
      logic [32:0] exp_b;
      int          p;
      int          waited;
      clk    = 1'b0;
      arst_n = 1'b0;
      wb_req = '0;
      lfsr   = 32'h038fdee7;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;

      read_status(d);
      check("status after reset", d, 32'd0);

      for (int i = 0; i < N_NORMAL; i++) begin
         take_bits(8, v);
         e = v[7:0];
         if (e == 8'h00)
            e = 8'h01;
         else if (e == 8'hff)
            e = 8'hfe;
         take_bits(23, v);
         run_operand({1'b0, e, v[22:0]});
      end

      // lfsr picks the leading one of the denormal
      for (int i = 0; i < N_DENORM; i++) begin
         take_bits(5, v);
         p = int'(v[4:0]) % 23;
         take_bits(23, v);
         x = {9'd0, (v[22:0] & ((23'd1 << p) - 23'd1)) | (23'd1 << p)};
         run_operand(x);
      end

      run_operand(32'h7f80_0000);
      run_operand(32'hff80_0000);
      run_operand(32'h0000_0000);
      run_operand(32'h8000_0000);
      run_operand(32'h7fc0_0000);
      run_operand(32'hffc0_0001);
      run_operand(32'h7f80_0001);   // signaling nan
      run_operand(32'hbf80_0000);
      run_operand(32'h8000_0001);
      run_operand(32'h3f80_0000);
      run_operand(32'h4080_0000);
      run_operand(32'h7f7f_ffff);
      run_operand(32'h0080_0000);
      run_operand(32'h0000_0001);
      for (int i = 0; i < 8; i++) begin
         take_bits(23, v);
         take_bits(1, w);
         run_operand({w[0], 8'hff, v[22:0] | 23'd1});
         take_bits(31, v);
         run_operand({1'b1, v[30:0] | 31'd1});
      end

      // second write lands while the first operation runs
      for (int i = 0; i < 6; i++) begin
         take_bits(31, v);
         x = (i % 2 == 0) ? 32'hc080_0000 : {1'b0, 8'h7e, v[22:0]};
         exp_a = model_sqrt(x);
         take_bits(31, v);
         w = {1'b0, 8'h40 + v[30:23] / 2, v[22:0]};
         exp_b = model_sqrt(w);
         write_data(x, waited);
         read_status(d);
         check("busy after first write", {31'd0, d[0]}, 32'd1);
         write_data(w, waited);
         check("second write held off", 32'(waited > 1), 32'd1);
         read_status(d);
         check("status during second", d, {30'd0, exp_a[32], 1'b1});
         read_data(d, waited);
         check($sformatf("second result for %h", w), d, exp_b[31:0]);
         read_status(d);
         check("status after second", d, {30'd0, exp_b[32], 1'b0});
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

//--- list.f
+incdir+design
design/sqrt_pkg.sv
design/operand_unpack.sv
design/rsqrt_seed.sv
design/newton_datapath.sv
design/result_pack.sv
design/sqrt_ctrl.sv
design/sqrt_top.sv
bench/sqrt_tb.sv

//--- Makefile
# Verilator build for the square-root unit and its testbench

VERILATOR ?= verilator
TOP       ?= sqrt_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
